/* cnn_quad.f */
rtl/quad_pkg.sv
rtl/quad_exec_if.sv
rtl/quad_config_regs.sv
rtl/quad_job_ctrl.sv
rtl/prefetch_fifo.sv
rtl/quad_weight_table.sv
rtl/quad_mac_engine.sv
rtl/cnn_quad.sv
tests/cnn_quad_assert.sv
tests/cnn_quad_tb.sv

/* rtl/cnn_quad.sv */
`timescale 1ns/1ns

module cnn_quad import quad_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                clk_core,
    input  logic                rst,

    input  logic                job_start,
    output logic                job_accept,
    output logic                job_fetch_request,
    input  logic                job_fetch_ack,
    input  logic                job_fetch_complete,
    output logic                job_complete,
    input  logic                job_complete_ack,

    input  logic                config_valid,
    output logic                config_accept,
    input  logic [CONFIG_W-1:0] config_data,

    input  logic                weight_valid,
    output logic                weight_ready,
    input  weight_t             weight_data,

    input  logic                pixel_valid,
    output logic                pixel_ready,
    input  pixel_t              pixel_data,

    output logic                result_valid,
    output result_t             result_data
);

    tap_idx_t kernel_last;
    win_cnt_t win_last;
    logic     relu_en;
    logic     wt_clear;
    logic     fetch_active;
    logic     fifo_empty;
    logic     fifo_rd;
    pixel_t   fifo_pixel;
    weight_t  tap_weight;

    quad_exec_if exec_bus ();

    ////////////////////
    // Control
    ////////////////////

    quad_config_regs u_config (
        .clk_core      (clk_core),
        .rst           (rst),
        .config_valid  (config_valid),
        .config_data   (config_data),
        .config_accept (config_accept),
        .kernel_last   (kernel_last),
        .win_last      (win_last),
        .relu_en       (relu_en),
        .wt_clear      (wt_clear)
    );

    quad_job_ctrl u_ctrl (
        .clk_core           (clk_core),
        .rst                (rst),
        .job_start          (job_start),
        .job_accept         (job_accept),
        .job_fetch_request  (job_fetch_request),
        .job_fetch_ack      (job_fetch_ack),
        .job_fetch_complete (job_fetch_complete),
        .job_complete       (job_complete),
        .job_complete_ack   (job_complete_ack),
        .kernel_last        (kernel_last),
        .win_last           (win_last),
        .fifo_empty         (fifo_empty),
        .fetch_active       (fetch_active),
        .exec               (exec_bus.ctrl)
    );

    ////////////////////
    // Data path
    ////////////////////

    prefetch_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk_core     (clk_core),
        .rst          (rst),
        .pixel_valid  (pixel_valid),
        .pixel_ready  (pixel_ready),
        .pixel_data   (pixel_data),
        .fetch_active (fetch_active),
        .rd_en        (fifo_rd),
        .rd_data      (fifo_pixel),
        .empty        (fifo_empty)
    );

    quad_weight_table u_weights (
        .clk_core     (clk_core),
        .rst          (rst),
        .weight_valid (weight_valid),
        .weight_ready (weight_ready),
        .weight_data  (weight_data),
        .wt_clear     (wt_clear),
        .rd_idx       (exec_bus.tap_idx),
        .rd_weight    (tap_weight)
    );

    quad_mac_engine u_mac (
        .clk_core     (clk_core),
        .rst          (rst),
        .pixel_in     (fifo_pixel),
        .weight_in    (tap_weight),
        .relu_en      (relu_en),
        .fifo_rd      (fifo_rd),
        .result_valid (result_valid),
        .result_data  (result_data),
        .exec         (exec_bus.engine)
    );

endmodule

/* rtl/prefetch_fifo.sv */
`timescale 1ns/1ns

module prefetch_fifo import quad_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic   clk_core,
    input  logic   rst,
    input  logic   pixel_valid,
    output logic   pixel_ready,
    input  pixel_t pixel_data,
    input  logic   fetch_active,
    input  logic   rd_en,
    output pixel_t rd_data,
    output logic   empty
);

    localparam int              AW      = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam logic [AW:0]     DEPTH_C = (AW + 1)'(FIFO_DEPTH);
    localparam logic [AW-1:0]   LAST_C  = AW'(FIFO_DEPTH - 1);

    pixel_t          buf_mem [FIFO_DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [AW:0]     count;
    logic            full;
    logic            push;
    logic            pop;

    assign full  = (count == DEPTH_C);
    assign empty = (count == '0);

    // Accept pixels only inside a fetch and with room left
    assign pixel_ready = pixel_valid && fetch_active && !full;
    assign push        = pixel_valid && pixel_ready;
    assign pop         = rd_en && !empty;

    // Head pixel is visible without a read latency
    assign rd_data = buf_mem[rd_ptr];

    always_ff @(posedge clk_core) begin
        if (push) begin
            buf_mem[wr_ptr] <= pixel_data;
        end
    end

    always_ff @(posedge clk_core) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_C) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_C) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* rtl/quad_config_regs.sv */
`timescale 1ns/1ns

module quad_config_regs import quad_pkg::*; (
    input  logic                clk_core,
    input  logic                rst,
    input  logic                config_valid,
    input  logic [CONFIG_W-1:0] config_data,
    output logic                config_accept,
    output tap_idx_t            kernel_last,
    output win_cnt_t            win_last,
    output logic                relu_en,
    output logic                wt_clear
);

    ////////////////////
    // Word fields
    ////////////////////

    tap_idx_t cfg_kernel;
    win_cnt_t cfg_windows;
    logic     cfg_relu;

    // Kernel size minus one, window count minus one, ReLU
    assign cfg_kernel  = config_data[3:0];
    assign cfg_windows = config_data[11:4];
    assign cfg_relu    = config_data[12];

    ////////////////////
    // Registers
    ////////////////////

    always_ff @(posedge clk_core) begin
        if (rst) begin
            config_accept <= 1'b0;
            kernel_last   <= '0;
            win_last      <= '0;
            relu_en       <= 1'b0;
        end else begin
            // One accept per valid cycle, a cycle later
            config_accept <= config_valid;
            if (config_valid) begin
                kernel_last <= cfg_kernel;
                win_last    <= cfg_windows;
                relu_en     <= cfg_relu;
            end
        end
    end

    // New configuration restarts weight loading at entry 0
    assign wt_clear = config_valid;

endmodule

/* rtl/quad_exec_if.sv */
`timescale 1ns/1ns

interface quad_exec_if import quad_pkg::*; ();

    // Per-tap controls from the job controller
    logic     execute;
    tap_idx_t tap_idx;
    logic     first_tap;
    logic     last_tap;

    // High while any MAC stage holds a tap
    logic     busy;

    modport ctrl (output execute, tap_idx, first_tap, last_tap, input busy);

    modport engine (input execute, tap_idx, first_tap, last_tap, output busy);

endinterface

/* rtl/quad_job_ctrl.sv */
`timescale 1ns/1ns

module quad_job_ctrl import quad_pkg::*; (
    input  logic        clk_core,
    input  logic        rst,
    input  logic        job_start,
    output logic        job_accept,
    output logic        job_fetch_request,
    input  logic        job_fetch_ack,
    input  logic        job_fetch_complete,
    output logic        job_complete,
    input  logic        job_complete_ack,
    input  tap_idx_t    kernel_last,
    input  win_cnt_t    win_last,
    input  logic        fifo_empty,
    output logic        fetch_active,
    quad_exec_if.ctrl   exec
);

    job_state_t state;
    tap_idx_t   tap_cnt;
    win_cnt_t   win_cnt;
    logic       tap_go;
    logic       window_done;

    ////////////////////
    // Tap stepping
    ////////////////////

    // One tap per cycle while pixels are waiting
    assign tap_go      = (state == ST_ACTIVE) && !fifo_empty;
    assign window_done = tap_go && (tap_cnt == kernel_last);

    assign exec.execute   = tap_go;
    assign exec.tap_idx   = tap_cnt;
    assign exec.first_tap = (tap_cnt == '0);
    assign exec.last_tap  = (tap_cnt == kernel_last);

    // Handshake levels follow the state directly
    assign job_fetch_request = (state == ST_FETCH);
    assign job_complete      = (state == ST_SEND_COMPLETE);

    ////////////////////
    // State machine
    ////////////////////

    always_ff @(posedge clk_core) begin
        if (rst) begin
            state      <= ST_IDLE;
            job_accept <= 1'b0;
            tap_cnt    <= '0;
            win_cnt    <= '0;
        end else begin
            job_accept <= 1'b0;

            if (tap_go) begin
                tap_cnt <= window_done ? '0 : tap_cnt + 1'b1;
            end

            case (state)
                ST_IDLE: begin
                    if (job_start) begin
                        job_accept <= 1'b1;
                        tap_cnt    <= '0;
                        win_cnt    <= '0;
                        state      <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    if (job_fetch_ack) begin
                        state <= ST_ACTIVE;
                    end
                end
                ST_ACTIVE: begin
                    // Next window fetch overlaps taps still in the MAC
                    if (window_done) begin
                        if (win_cnt == win_last) begin
                            state <= ST_DRAIN;
                        end else begin
                            win_cnt <= win_cnt + 1'b1;
                            state   <= ST_FETCH;
                        end
                    end
                end
                ST_DRAIN: begin
                    if (!exec.busy) begin
                        state <= ST_SEND_COMPLETE;
                    end
                end
                ST_SEND_COMPLETE: begin
                    if (job_complete_ack) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    ////////////////////
    // Fetch window
    ////////////////////

    // Pixels are accepted from ack until complete
    always_ff @(posedge clk_core) begin
        if (rst) begin
            fetch_active <= 1'b0;
        end else if (job_fetch_request && job_fetch_ack) begin
            fetch_active <= 1'b1;
        end else if (job_fetch_complete) begin
            fetch_active <= 1'b0;
        end
    end

endmodule

/* rtl/quad_mac_engine.sv */
`timescale 1ns/1ns

module quad_mac_engine import quad_pkg::*; (
    input  logic        clk_core,
    input  logic        rst,
    input  pixel_t      pixel_in,
    input  weight_t     weight_in,
    input  logic        relu_en,
    output logic        fifo_rd,
    output logic        result_valid,
    output result_t     result_data,
    quad_exec_if.engine exec
);

    logic    s1_valid;
    logic    s1_first;
    logic    s1_last;
    pixel_t  s1_pixel;
    weight_t s1_weight;

    logic    s2_valid;
    logic    s2_first;
    logic    s2_last;
    result_t s2_prod;

    result_t acc;

    // Each executed tap consumes one buffered pixel
    assign fifo_rd = exec.execute;

    ////////////////////
    // Valid pipeline
    ////////////////////

    always_ff @(posedge clk_core) begin
        if (rst) begin
            s1_valid     <= 1'b0;
            s2_valid     <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            s1_valid     <= exec.execute;
            s2_valid     <= s1_valid;
            result_valid <= s2_valid && s2_last;
        end
    end

    ////////////////////
    // Data path
    ////////////////////

    always_ff @(posedge clk_core) begin
        // Stage 1 clamps negative pixels to zero under ReLU
        s1_pixel  <= (relu_en && pixel_in[PIXEL_W-1]) ? '0 : pixel_in;
        s1_weight <= weight_in;
        s1_first  <= exec.first_tap;
        s1_last   <= exec.last_tap;

        // Stage 2 forms the signed product at the result width
        s2_prod  <= s1_pixel * s1_weight;
        s2_first <= s1_first;
        s2_last  <= s1_last;

        // Stage 3 restarts the sum on a window's first tap
        if (s2_valid) begin
            acc <= s2_first ? s2_prod : acc + s2_prod;
        end
    end

    assign result_data = acc;

    // Taps still in flight ahead of the accumulator
    assign exec.busy = s1_valid || s2_valid;

endmodule

/* rtl/quad_pkg.sv */
package quad_pkg;

    ////////////////////
    // Data widths
    ////////////////////

    localparam int PIXEL_W  = 8;
    localparam int WEIGHT_W = 8;
    localparam int RESULT_W = 16;
    localparam int CONFIG_W = 16;

    // Largest kernel, one weight per tap
    localparam int MAX_TAPS = 16;
    localparam int TAP_W    = $clog2(MAX_TAPS);
    localparam int WIN_W    = 8;

    ////////////////////
    // Types
    ////////////////////

    typedef logic signed [PIXEL_W-1:0]  pixel_t;
    typedef logic signed [WEIGHT_W-1:0] weight_t;

    // Accumulator wraps on overflow
    typedef logic signed [RESULT_W-1:0] result_t;

    typedef logic [TAP_W-1:0] tap_idx_t;
    typedef logic [WIN_W-1:0] win_cnt_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_ACTIVE,
        ST_DRAIN,
        ST_SEND_COMPLETE
    } job_state_t;

endpackage

/* rtl/quad_weight_table.sv */
`timescale 1ns/1ns

module quad_weight_table import quad_pkg::*; (
    input  logic     clk_core,
    input  logic     rst,
    input  logic     weight_valid,
    output logic     weight_ready,
    input  weight_t  weight_data,
    input  logic     wt_clear,
    input  tap_idx_t rd_idx,
    output weight_t  rd_weight
);

    weight_t  wt_mem [MAX_TAPS];
    tap_idx_t wr_ptr;
    tap_idx_t wr_addr;

    // Table never stalls the weight stream
    assign weight_ready = weight_valid;

    // A clear in the same cycle lands the weight in entry 0
    assign wr_addr = wt_clear ? '0 : wr_ptr;

    always_ff @(posedge clk_core) begin
        if (weight_valid) begin
            wt_mem[wr_addr] <= weight_data;
        end
    end

    always_ff @(posedge clk_core) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (weight_valid) begin
            wr_ptr <= wr_addr + 1'b1;
        end else if (wt_clear) begin
            wr_ptr <= '0;
        end
    end

    assign rd_weight = wt_mem[rd_idx];

endmodule

/* tests/cnn_quad_assert.sv */
`timescale 1ns/1ns

module cnn_quad_assert import quad_pkg::*; (
    input logic       clk_core,
    input logic       rst,
    input logic       job_accept,
    input logic       job_fetch_request,
    input logic       job_fetch_ack,
    input logic       job_complete,
    input logic       job_complete_ack,
    input logic       result_valid,
    input job_state_t state
);

    // Number of failed assertions
    int assert_errors = 0;

    accept_pulse: assert property (@(posedge clk_core) disable iff (rst)
        job_accept |=> !job_accept)
        else begin
            $error("job_accept held for more than one cycle");
            assert_errors++;
        end

    // Request is a level until acknowledged
    fetch_hold: assert property (@(posedge clk_core) disable iff (rst)
        job_fetch_request && !job_fetch_ack |=> job_fetch_request)
        else begin
            $error("job_fetch_request dropped before job_fetch_ack");
            assert_errors++;
        end

    complete_hold: assert property (@(posedge clk_core) disable iff (rst)
        job_complete && !job_complete_ack |=> job_complete)
        else begin
            $error("job_complete dropped before job_complete_ack");
            assert_errors++;
        end

    idle_quiet: assert property (@(posedge clk_core) disable iff (rst)
        (state == ST_IDLE) |-> !result_valid)
        else begin
            $error("result_valid high while the controller is idle");
            assert_errors++;
        end

endmodule

bind cnn_quad cnn_quad_assert u_assert (
    .clk_core          (clk_core),
    .rst               (rst),
    .job_accept        (job_accept),
    .job_fetch_request (job_fetch_request),
    .job_fetch_ack     (job_fetch_ack),
    .job_complete      (job_complete),
    .job_complete_ack  (job_complete_ack),
    .result_valid      (result_valid),
    .state             (u_ctrl.state)
);

/* tests/cnn_quad_tb.sv */
`timescale 1ns/1ns

module cnn_quad_tb import quad_pkg::*; ();

    localparam int NUM_TESTS = 5;

    // One row per job with kernel size, window count, ReLU, weight reload and pixel gaps
    typedef struct packed {
        logic [4:0] kernel;
        logic [8:0] windows;
        logic       relu;
        logic       load;
        logic       gaps;
    } test_row_t;

    logic                clk_core;
    logic                rst;
    logic                job_start;
    logic                job_accept;
    logic                job_fetch_request;
    logic                job_fetch_ack;
    logic                job_fetch_complete;
    logic                job_complete;
    logic                job_complete_ack;
    logic                config_valid;
    logic                config_accept;
    logic [CONFIG_W-1:0] config_data;
    logic                weight_valid;
    logic                weight_ready;
    weight_t             weight_data;
    logic                pixel_valid;
    logic                pixel_ready;
    pixel_t              pixel_data;
    logic                result_valid;
    result_t             result_data;

    test_row_t rows [NUM_TESTS];
    weight_t   wt_model [MAX_TAPS];
    result_t   exp_q [$];
    int        n_checks;
    int        n_errors;
    int        n_results;
    int        n_fetches;
    int        cycles;
    int        cycle_limit;
    logic      req_q;

    cnn_quad #(.FIFO_DEPTH(16)) dut0 (.*);

    always #20 clk_core = ~clk_core;

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic check_result(input string name, input result_t got, input result_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error: %s got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error: %s got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input win_cnt_t got, input win_cnt_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error: %s got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    ////////////////////
    // Monitors
    ////////////////////

    always @(posedge clk_core) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: run still going after %0d cycles", cycle_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // Count fetch requests and score results in order
    always @(posedge clk_core) begin
        req_q <= job_fetch_request;
        if (!rst && job_fetch_request && !req_q) begin
            n_fetches++;
        end
        if (!rst && result_valid) begin
            if (exp_q.size() == 0) begin
                n_errors++;
                $display("result_valid pulsed with no window outstanding");
            end else begin
                check_result("result_data", result_data, exp_q.pop_front());
            end
            n_results++;
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic write_config(input test_row_t row);
        @(negedge clk_core);
        config_valid = 1'b1;
        config_data  = {3'b000, row.relu, 8'(row.windows - 1), 4'(row.kernel - 1)};
        @(posedge clk_core);
        check_flag("config_accept", config_accept, 1'b0);
        @(negedge clk_core);
        config_valid = 1'b0;
        @(posedge clk_core);
        check_flag("config_accept", config_accept, 1'b1);
        @(posedge clk_core);
        check_flag("config_accept", config_accept, 1'b0);
    endtask

    task automatic load_weights(input int k);
        int i;
        for (i = 0; i < k; i++) begin
            @(negedge clk_core);
            weight_valid = 1'b1;
            weight_data  = weight_t'($urandom);
            wt_model[i]  = weight_data;
            @(posedge clk_core);
            check_flag("weight_ready", weight_ready, 1'b1);
        end
        @(negedge clk_core);
        weight_valid = 1'b0;
    endtask

    // Answers one fetch and models the window's dot product
    task automatic serve_window(input int k, input logic relu, input logic gaps);
        pixel_t  pix;
        result_t sum;
        int      sent;
        sum  = '0;
        sent = 0;
        do @(posedge clk_core); while (!job_fetch_request);
        @(negedge clk_core);
        job_fetch_ack = 1'b1;
        @(negedge clk_core);
        job_fetch_ack = 1'b0;
        while (sent < k) begin
            pixel_valid = !gaps || ($urandom % 4 != 0);
            pixel_data  = pixel_t'($urandom);
            @(posedge clk_core);
            // Fetch is open and a window never fills the FIFO
            check_flag("pixel_ready", pixel_ready, pixel_valid);
            if (pixel_valid && pixel_ready) begin
                pix  = (relu && pixel_data < 0) ? pixel_t'(0) : pixel_data;
                sum  = sum + result_t'(pix) * result_t'(wt_model[sent]);
                sent = sent + 1;
            end
            @(negedge clk_core);
        end
        exp_q.push_back(sum);
        pixel_valid        = 1'b0;
        job_fetch_complete = 1'b1;
        @(negedge clk_core);
        job_fetch_complete = 1'b0;
    endtask

    task automatic run_job(input int windows);
        @(negedge clk_core);
        job_start = 1'b1;
        @(negedge clk_core);
        job_start = 1'b0;
        @(posedge clk_core);
        check_flag("job_accept", job_accept, 1'b1);
        // Second start while busy
        @(negedge clk_core);
        job_start = 1'b1;
        @(negedge clk_core);
        job_start = 1'b0;
        @(posedge clk_core);
        check_flag("job_accept", job_accept, 1'b0);
        do @(posedge clk_core); while (!job_complete);
        @(negedge clk_core);
        if (n_results != windows) begin
            n_errors++;
            $display("job_complete came with %0d of %0d results returned", n_results, windows);
        end
        check_count("fetch requests", win_cnt_t'(n_fetches), win_cnt_t'(windows));
        repeat (2) begin
            @(posedge clk_core);
            check_flag("job_complete", job_complete, 1'b1);
        end
        @(negedge clk_core);
        job_complete_ack = 1'b1;
        @(negedge clk_core);
        job_complete_ack = 1'b0;
        @(posedge clk_core);
        check_flag("job_complete", job_complete, 1'b0);
    endtask

    task automatic run_test(input test_row_t row);
        int w;
        @(negedge clk_core);
        n_results = 0;
        n_fetches = 0;
        write_config(row);
        if (row.load) begin
            load_weights(row.kernel);
        end
        fork
            begin
                for (w = 0; w < row.windows; w++) begin
                    serve_window(row.kernel, row.relu, row.gaps);
                end
            end
            run_job(row.windows);
        join
    endtask

    initial begin
        int t;
        int errs_before;
        void'($urandom(32'hf3eb));
        clk_core           = 1'b0;
        rst                = 1'b1;
        job_start          = 1'b0;
        job_fetch_ack      = 1'b0;
        job_fetch_complete = 1'b0;
        job_complete_ack   = 1'b0;
        config_valid       = 1'b0;
        config_data        = '0;
        weight_valid       = 1'b0;
        weight_data        = '0;
        pixel_valid        = 1'b0;
        pixel_data         = '0;
        rows[0] = '{5'd4, 9'd1, 1'b0, 1'b1, 1'b0};
        rows[1] = '{5'd9, 9'd3, 1'b1, 1'b1, 1'b0};
        rows[2] = '{5'd9, 9'd5, 1'b0, 1'b0, 1'b1};
        rows[3] = '{5'd16, 9'd4, 1'b1, 1'b1, 1'b1};
        rows[4] = '{5'd1, 9'd2, 1'b0, 1'b1, 1'b1};
        cycle_limit = 0;
        for (t = 0; t < NUM_TESTS; t++) begin
            cycle_limit += rows[t].windows * (rows[t].kernel + 10) + 40;
        end
        cycle_limit = 2 * cycle_limit;
        repeat (4) @(posedge clk_core);
        @(negedge clk_core);
        rst = 1'b0;
        for (t = 0; t < NUM_TESTS; t++) begin
            errs_before = n_errors;
            run_test(rows[t]);
            $display("test %0d: kernel %0d, windows %0d, relu %0d, gaps %0d: %s", t,
                     rows[t].kernel, rows[t].windows, rows[t].relu, rows[t].gaps,
                     (n_errors == errs_before) ? "ok" : "failed");
        end
        n_errors = n_errors + dut0.u_assert.assert_errors;
        $display("checks %0d, errors %0d, assertion failures %0d", n_checks, n_errors,
                 dut0.u_assert.assert_errors);
        if (n_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
